// File: list.f
+incdir+.
lsu_op_pkg.sv
mem_bus_pkg.sv
mem_ctrl.sv
store_aligner.sv
data_memory.sv
load_extender.sv
mem_stage.sv
tb_mem_stage.sv

// File: tb_mem_stage.sv
`include "mem_cfg.svh"

module tb_mem_stage;

  localparam int BYTE_AW = `MEM_ADDR_W + 2;        // Byte address width
  localparam int NBYTES  = 4 << `MEM_ADDR_W;       // Reference memory size in bytes

  logic                   i_clk;
  logic                   i_rst;
  logic                   i_valid;
  lsu_op_pkg::lsu_op_e    i_op;
  logic [BYTE_AW-1:0]     i_addr;
  logic [`MEM_DATA_W-1:0] i_wdata;
  logic [`MEM_DATA_W-1:0] o_rdata;
  logic                   o_rvalid;
  logic                   o_exc;

  // Stimulus table, one entry per cycle
  lsu_op_pkg::lsu_op_e    op_q[$];
  logic [BYTE_AW-1:0]     addr_q[$];
  logic [`MEM_DATA_W-1:0] data_q[$];
  logic                   valid_q[$];       // Request strobe for each entry

  logic [7:0]             ref_mem [NBYTES]; // Byte-level reference memory
  logic [`MEM_DATA_W-1:0] exp_rdata;        // Expected response for the last request
  logic                   exp_rvalid;
  logic                   exp_exc;
  int                     seed;
  int                     cycle_cnt;

  mem_stage dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .o_rdata  (o_rdata),
    .o_rvalid (o_rvalid),
    .o_exc    (o_exc)
  );

  always #5 i_clk = ~i_clk; // Period 10

  // Run limit from the table length
  always @(posedge i_clk) begin
    if (i_rst) begin
      cycle_cnt = 0;
    end else begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > op_q.size() + 20) begin
        $display("Timeout: run did not finish within the cycle limit");
        $display("TEST FAIL");
        $fatal(1);
      end
    end
  end

  function automatic int access_bytes(lsu_op_pkg::lsu_op_e op);
    case (op)
      lsu_op_pkg::OP_LB, lsu_op_pkg::OP_LBU, lsu_op_pkg::OP_SB: return 1;
      lsu_op_pkg::OP_LH, lsu_op_pkg::OP_LHU, lsu_op_pkg::OP_SH: return 2;
      lsu_op_pkg::OP_LW, lsu_op_pkg::OP_SW:                     return 4;
      default:                                                  return 0;
    endcase
  endfunction

  function automatic bit is_load_op(lsu_op_pkg::lsu_op_e op);
    return op inside {lsu_op_pkg::OP_LB, lsu_op_pkg::OP_LBU, lsu_op_pkg::OP_LH,
                      lsu_op_pkg::OP_LHU, lsu_op_pkg::OP_LW};
  endfunction

  // Little-endian read of the reference bytes, then extension
  function automatic logic [31:0] ref_read(lsu_op_pkg::lsu_op_e op, int addr);
    logic [31:0] val;
    int          n;
    n   = access_bytes(op);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = val | (32'(ref_mem[addr + k]) << (8 * k));
    end
    if (op == lsu_op_pkg::OP_LB && val[7]) begin
      val = val | 32'hFFFF_FF00; // Negative byte
    end
    if (op == lsu_op_pkg::OP_LH && val[15]) begin
      val = val | 32'hFFFF_0000; // Negative halfword
    end
    return val;
  endfunction

  task automatic ref_write(lsu_op_pkg::lsu_op_e op, int addr, logic [31:0] data);
    int n;
    n = access_bytes(op);
    for (int k = 0; k < n; k++) begin
      ref_mem[addr + k] = data[8*k +: 8]; // Low bytes of the store data
    end
  endtask

  task automatic push_entry(lsu_op_pkg::lsu_op_e op, logic [BYTE_AW-1:0] addr,
                            logic [31:0] data);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    valid_q.push_back(op != lsu_op_pkg::OP_NONE);
  endtask

  // Opcode and address on the bus while the strobe stays low
  task automatic push_unstrobed(lsu_op_pkg::lsu_op_e op, logic [BYTE_AW-1:0] addr,
                                logic [31:0] data);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    valid_q.push_back(1'b0);
  endtask

  task automatic push_rand_store(lsu_op_pkg::lsu_op_e op, logic [BYTE_AW-1:0] addr);
    push_entry(op, addr, $random(seed));
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("Error: %s expected %h, got %h", name, expected, actual);
        $display("TEST FAIL");
        $fatal(1);
      end
  endtask

  task automatic check_outputs();
    check_value("o_rvalid", 32'(exp_rvalid), 32'(o_rvalid));
    check_value("o_exc", 32'(exp_exc), 32'(o_exc));
    check_value("o_rdata", exp_rdata, o_rdata);
  endtask

  // Drive one entry and work out what the stage answers next cycle
  task automatic drive_entry(int i);
    int n;
    n          = valid_q[i] ? access_bytes(op_q[i]) : 0; // No strobe, no access
    i_valid    = valid_q[i];
    i_op       = op_q[i];
    i_addr     = addr_q[i];
    i_wdata    = data_q[i];
    exp_rdata  = '0;
    exp_rvalid = 1'b0;
    exp_exc    = 1'b0;
    if (n != 0) begin
      if ((int'(addr_q[i]) % n) != 0) begin
        exp_exc = 1'b1; // Blocked with memory untouched
      end else if (is_load_op(op_q[i])) begin
        exp_rvalid = 1'b1;
        exp_rdata  = ref_read(op_q[i], int'(addr_q[i]));
      end else begin
        ref_write(op_q[i], int'(addr_q[i]), data_q[i]);
      end
    end
  endtask

  task automatic build_table();
    repeat (3) push_entry(lsu_op_pkg::OP_NONE, '0, '0); // Idle after reset
    push_rand_store(lsu_op_pkg::OP_SW, 12'h010);          // Word store then load
    push_entry(lsu_op_pkg::OP_LW, 12'h010, '0);
    push_entry(lsu_op_pkg::OP_SW, 12'h020, 32'h1122_3344); // Byte lane merges
    push_rand_store(lsu_op_pkg::OP_SB, 12'h021);
    push_entry(lsu_op_pkg::OP_LW, 12'h020, '0);
    push_rand_store(lsu_op_pkg::OP_SB, 12'h023);
    push_entry(lsu_op_pkg::OP_LW, 12'h020, '0);
    push_rand_store(lsu_op_pkg::OP_SB, 12'h020);
    push_rand_store(lsu_op_pkg::OP_SB, 12'h022);
    push_entry(lsu_op_pkg::OP_LW, 12'h020, '0);
    push_entry(lsu_op_pkg::OP_SW, 12'h024, 32'hA5A5_A5A5); // Halfword lanes
    push_rand_store(lsu_op_pkg::OP_SH, 12'h024);
    push_entry(lsu_op_pkg::OP_LW, 12'h024, '0);
    push_rand_store(lsu_op_pkg::OP_SH, 12'h026);
    push_entry(lsu_op_pkg::OP_LW, 12'h024, '0);
    push_entry(lsu_op_pkg::OP_SW, 12'h030, 32'h80FF_7F01); // Extension patterns
    for (int k = 0; k < 4; k++) begin
      push_entry(lsu_op_pkg::OP_LB, 12'h030 + k, '0);
      push_entry(lsu_op_pkg::OP_LBU, 12'h030 + k, '0);
    end
    push_entry(lsu_op_pkg::OP_LH, 12'h030, '0);
    push_entry(lsu_op_pkg::OP_LH, 12'h032, '0);
    push_entry(lsu_op_pkg::OP_LHU, 12'h030, '0);
    push_entry(lsu_op_pkg::OP_LHU, 12'h032, '0);
    push_entry(lsu_op_pkg::OP_SW, 12'h034, 32'h7FFF_8000);
    push_entry(lsu_op_pkg::OP_LH, 12'h034, '0);
    push_entry(lsu_op_pkg::OP_LH, 12'h036, '0);
    push_entry(lsu_op_pkg::OP_LHU, 12'h034, '0);
    push_entry(lsu_op_pkg::OP_SW, 12'h040, 32'hDEAD_BEEF); // Misaligned accesses
    push_rand_store(lsu_op_pkg::OP_SH, 12'h041);
    push_rand_store(lsu_op_pkg::OP_SH, 12'h043);
    push_rand_store(lsu_op_pkg::OP_SW, 12'h042);
    push_rand_store(lsu_op_pkg::OP_SW, 12'h041);
    push_rand_store(lsu_op_pkg::OP_SW, 12'h043);
    push_entry(lsu_op_pkg::OP_LH, 12'h041, '0);
    push_entry(lsu_op_pkg::OP_LHU, 12'h043, '0);
    push_entry(lsu_op_pkg::OP_LW, 12'h042, '0);
    push_entry(lsu_op_pkg::OP_LW, 12'h041, '0);
    push_entry(lsu_op_pkg::OP_LW, 12'h040, '0);            // Still the old word
    push_unstrobed(lsu_op_pkg::OP_SW, 12'h040, 32'h0BAD_F00D); // Ignored without strobe
    push_unstrobed(lsu_op_pkg::OP_SB, 12'h041, 32'h0000_0055);
    push_unstrobed(lsu_op_pkg::OP_LW, 12'h040, '0);
    push_entry(lsu_op_pkg::OP_LW, 12'h040, '0);
    push_entry(lsu_op_pkg::OP_NONE, '0, '0);
    push_rand_store(lsu_op_pkg::OP_SW, 12'hFFC);            // Top of memory
    push_entry(lsu_op_pkg::OP_LW, 12'h010, '0);            // Back-to-back loads
    push_entry(lsu_op_pkg::OP_LW, 12'h020, '0);
    push_entry(lsu_op_pkg::OP_LB, 12'h033, '0);
    push_entry(lsu_op_pkg::OP_LHU, 12'h026, '0);
    push_entry(lsu_op_pkg::OP_LW, 12'hFFC, '0);
    push_entry(lsu_op_pkg::OP_LBU, 12'hFFF, '0);
    push_entry(lsu_op_pkg::OP_LW, 12'h100, '0);            // Never written
    repeat (2) push_entry(lsu_op_pkg::OP_NONE, '0, '0);
  endtask

  initial begin
    seed       = 93;
    cycle_cnt  = 0;
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_valid    = 1'b0;
    i_op       = lsu_op_pkg::OP_NONE;
    i_addr     = '0;
    i_wdata    = '0;
    exp_rdata  = '0;
    exp_rvalid = 1'b0;
    exp_exc    = 1'b0;
    for (int a = 0; a < NBYTES; a++) begin
      ref_mem[a] = 8'h00; // RAM powers up cleared
    end
    build_table();
    repeat (3) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    for (int i = 0; i < op_q.size(); i++) begin
      @(posedge i_clk);
      #1;
      check_outputs(); // Answer to the entry driven one cycle ago
      drive_entry(i);
    end
    @(posedge i_clk);
    #1;
    check_outputs();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: mem_stage.sv
`include "mem_cfg.svh"

module mem_stage (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_valid,  // Request strobe
  input  lsu_op_pkg::lsu_op_e    i_op,
  input  logic [`MEM_ADDR_W+1:0] i_addr,   // Byte address
  input  logic [`MEM_DATA_W-1:0] i_wdata,
  output logic [`MEM_DATA_W-1:0] o_rdata,  // Load data, one cycle after request
  output logic                   o_rvalid,
  output logic                   o_exc     // Misaligned request, one cycle after
);

  // Request side
  mem_bus_pkg::acc_size_e size;
  logic [1:0]             offset;
  logic                   wr_en;
  logic                   rd_en;
  logic [`MEM_ADDR_W-1:0] word_addr;

  // Load context, aligned with the RAM output
  logic                   ld_valid;
  mem_bus_pkg::acc_size_e ld_size;
  logic                   ld_signed;
  logic [1:0]             ld_offset;

  // Datapath
  logic [`MEM_DATA_W-1:0] lane_data;
  mem_bus_pkg::lane_t     byte_en;
  logic [`MEM_DATA_W-1:0] raw_word;

  mem_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_byte_addr  (i_addr),
    .o_size       (size),
    .o_offset     (offset),
    .o_wr_en      (wr_en),
    .o_rd_en      (rd_en),
    .o_word_addr  (word_addr),
    .o_ld_valid   (ld_valid),
    .o_ld_size    (ld_size),
    .o_ld_signed  (ld_signed),
    .o_ld_offset  (ld_offset),
    .o_misaligned (o_exc)       // Already registered in control
  );

  store_aligner u_align (
    .i_wr_en     (wr_en),
    .i_size      (size),
    .i_offset    (offset),
    .i_wdata     (i_wdata),
    .o_lane_data (lane_data),
    .o_byte_en   (byte_en)
  );

  data_memory u_mem (
    .i_clk     (i_clk),
    .i_addr    (word_addr),
    .i_data    (lane_data),
    .i_byte_en (byte_en),
    .i_rd_en   (rd_en),
    .o_data    (raw_word)
  );

  load_extender u_ext (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_ld_valid  (ld_valid),
    .i_ld_size   (ld_size),
    .i_ld_signed (ld_signed),
    .i_ld_offset (ld_offset),
    .i_raw       (raw_word),
    .o_rdata     (o_rdata),
    .o_rvalid    (o_rvalid)
  );

endmodule

// File: load_extender.sv
`include "mem_cfg.svh"

module load_extender (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_ld_valid,  // Load result due this cycle
  input  mem_bus_pkg::acc_size_e i_ld_size,
  input  logic                   i_ld_signed, // Sign-extend the result
  input  logic [1:0]             i_ld_offset, // Byte within the word
  input  logic [`MEM_DATA_W-1:0] i_raw,       // Word from the RAM read register
  output logic [`MEM_DATA_W-1:0] o_rdata,
  output logic                   o_rvalid
);

  logic [`MEM_DATA_W-1:0]   shifted; // Selected lane moved to bit 0
  logic [`MEM_COL_W-1:0]    lo_byte;
  logic [2*`MEM_COL_W-1:0]  lo_half;
  logic [`MEM_DATA_W-1:0]   ext;     // Extended result

  assign shifted = i_raw >> (i_ld_offset * `MEM_COL_W);
  assign lo_byte = shifted[`MEM_COL_W-1:0];
  assign lo_half = shifted[2*`MEM_COL_W-1:0];

  // Sign or zero fill above the loaded lane
  always_comb begin
    case (i_ld_size)
      mem_bus_pkg::SZ_BYTE:
        ext = {{(`MEM_DATA_W-`MEM_COL_W){i_ld_signed & lo_byte[`MEM_COL_W-1]}}, lo_byte};
      mem_bus_pkg::SZ_HALF:
        ext = {{(`MEM_DATA_W-2*`MEM_COL_W){i_ld_signed & lo_half[2*`MEM_COL_W-1]}},
               lo_half};
      default:
        ext = i_raw;                                          // Full word
    endcase
  end

  assign o_rdata  = i_ld_valid ? ext : '0; // Zero while no load result
  assign o_rvalid = i_ld_valid;

  // Offset held in the context must match the size it travels with
  a_ld_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    i_ld_valid |-> ((i_ld_size == mem_bus_pkg::SZ_BYTE) ||
                    (i_ld_size == mem_bus_pkg::SZ_HALF && !i_ld_offset[0]) ||
                    (i_ld_size == mem_bus_pkg::SZ_WORD && i_ld_offset == 2'b00)))
    else $error("load_extender misaligned load context, offset %0d", i_ld_offset);

endmodule

// File: data_memory.sv
`include "mem_cfg.svh"

module data_memory (
  input  logic                   i_clk,
  input  logic [`MEM_ADDR_W-1:0] i_addr,    // Word address
  input  logic [`MEM_DATA_W-1:0] i_data,    // Lane-aligned write data
  input  mem_bus_pkg::lane_t     i_byte_en, // Per-lane write enable
  input  logic                   i_rd_en,   // Read register update
  output logic [`MEM_DATA_W-1:0] o_data     // Registered read word
);

  localparam int DEPTH = 2 ** `MEM_ADDR_W; // 1024 words

  logic [`MEM_DATA_W-1:0] ram [DEPTH]; // Block RAM array
  logic [`MEM_DATA_W-1:0] rd_q;        // Output register

  // Memory powers up cleared, contents survive reset
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      ram[i] = '0;
    end
  end

  // Byte-write port, one column per lane
  always @(posedge i_clk) begin
    for (int l = 0; l < `MEM_NB_COL; l++) begin
      if (i_byte_en[l]) begin
        ram[i_addr][l*`MEM_COL_W +: `MEM_COL_W] <= i_data[l*`MEM_COL_W +: `MEM_COL_W];
      end
    end
  end

  // Read-first, same-edge store leaves the old word in rd_q
  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      rd_q <= ram[i_addr];
    end
  end

  assign o_data = rd_q;

endmodule

// File: store_aligner.sv
`include "mem_cfg.svh"

module store_aligner (
  input  logic                   i_wr_en,     // Write-gate from control
  input  mem_bus_pkg::acc_size_e i_size,
  input  logic [1:0]             i_offset,    // Byte within the word
  input  logic [`MEM_DATA_W-1:0] i_wdata,     // Store data, value in the low bits
  output logic [`MEM_DATA_W-1:0] o_lane_data, // Data placed on every candidate lane
  output mem_bus_pkg::lane_t     o_byte_en
);

  mem_bus_pkg::lane_t lane_sel; // Lanes chosen before gating

  // Copy the low byte or halfword into each lane position
  always_comb begin
    case (i_size)
      mem_bus_pkg::SZ_BYTE:
        o_lane_data = {`MEM_NB_COL{i_wdata[`MEM_COL_W-1:0]}};
      mem_bus_pkg::SZ_HALF:
        o_lane_data = {(`MEM_NB_COL/2){i_wdata[2*`MEM_COL_W-1:0]}};
      default:
        o_lane_data = i_wdata;                              // Word goes through as is
    endcase
  end

  // Lane select from size and offset
  always_comb begin
    case (i_size)
      mem_bus_pkg::SZ_BYTE:
        lane_sel = mem_bus_pkg::lane_t'(1) << i_offset;     // Single lane
      mem_bus_pkg::SZ_HALF:
        lane_sel = mem_bus_pkg::lane_t'(3) << {i_offset[1], 1'b0}; // Low or high pair
      mem_bus_pkg::SZ_WORD:
        lane_sel = '1;                                      // All four lanes
      default:
        lane_sel = '0;
    endcase
  end

  assign o_byte_en = i_wr_en ? lane_sel : '0; // No lane written without the gate

  // Checked after the combinational logic settles
  always_comb begin
    a_en_gated: assert final (i_wr_en || (o_byte_en == '0))
      else $error("store_aligner byte enable set with write-gate low");
  end

endmodule

// File: mem_ctrl.sv
`include "mem_cfg.svh"

module mem_ctrl (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_valid,       // One-cycle request strobe
  input  lsu_op_pkg::lsu_op_e    i_op,
  input  logic [`MEM_ADDR_W+1:0] i_byte_addr,
  output mem_bus_pkg::acc_size_e o_size,        // Size of the current request
  output logic [1:0]             o_offset,      // Byte within the word
  output logic                   o_wr_en,       // Valid aligned store
  output logic                   o_rd_en,       // Valid aligned load
  output logic [`MEM_ADDR_W-1:0] o_word_addr,
  output logic                   o_ld_valid,    // Load result due this cycle
  output mem_bus_pkg::acc_size_e o_ld_size,
  output logic                   o_ld_signed,
  output logic [1:0]             o_ld_offset,
  output logic                   o_misaligned   // Previous request was misaligned
);

  logic is_load;   // Opcode is one of the loads
  logic is_store;  // Opcode is one of the stores
  logic is_signed; // Load result is sign-extended
  logic aligned;   // Address fits the access size

  assign o_offset    = i_byte_addr[1:0];
  assign o_word_addr = i_byte_addr[`MEM_ADDR_W+1:2]; // Drop the byte offset

  // Opcode decode
  always_comb begin
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_signed = 1'b0;
    o_size    = mem_bus_pkg::SZ_WORD;
    case (i_op)
      lsu_op_pkg::OP_LB: begin
        is_load   = 1'b1;
        is_signed = 1'b1;
        o_size    = mem_bus_pkg::SZ_BYTE;
      end
      lsu_op_pkg::OP_LBU: begin
        is_load = 1'b1;
        o_size  = mem_bus_pkg::SZ_BYTE;
      end
      lsu_op_pkg::OP_LH: begin
        is_load   = 1'b1;
        is_signed = 1'b1;
        o_size    = mem_bus_pkg::SZ_HALF;
      end
      lsu_op_pkg::OP_LHU: begin
        is_load = 1'b1;
        o_size  = mem_bus_pkg::SZ_HALF;
      end
      lsu_op_pkg::OP_LW:  is_load  = 1'b1;
      lsu_op_pkg::OP_SB: begin
        is_store = 1'b1;
        o_size   = mem_bus_pkg::SZ_BYTE;
      end
      lsu_op_pkg::OP_SH: begin
        is_store = 1'b1;
        o_size   = mem_bus_pkg::SZ_HALF;
      end
      lsu_op_pkg::OP_SW:  is_store = 1'b1;
      default: ;                                     // OP_NONE and unused codes
    endcase
  end

  // Halfword needs bit 0 clear, word needs bits 1:0 clear
  always_comb begin
    case (o_size)
      mem_bus_pkg::SZ_HALF: aligned = ~i_byte_addr[0];
      mem_bus_pkg::SZ_WORD: aligned = (i_byte_addr[1:0] == 2'b00);
      default:              aligned = 1'b1;
    endcase
  end

  assign o_wr_en = i_valid & is_store & aligned; // Misaligned stores write nothing
  assign o_rd_en = i_valid & is_load & aligned;  // Misaligned loads read nothing

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ld_valid   <= 1'b0;
      o_misaligned <= 1'b0;
    end else begin
      o_ld_valid   <= o_rd_en;                              // Meets the RAM read register
      o_misaligned <= i_valid & (is_load | is_store) & ~aligned;
    end
  end

  // Load context travels alongside the RAM read
  always_ff @(posedge i_clk) begin
    o_ld_size   <= o_size;
    o_ld_signed <= is_signed;
    o_ld_offset <= o_offset;
  end

  a_no_rd_wr: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_wr_en && o_rd_en))
    else $error("mem_ctrl read and write enabled together");

endmodule

// File: mem_bus_pkg.sv
`include "mem_cfg.svh"

// Types on the memory side of the stage
package mem_bus_pkg;

  // Access size decoded from the opcode
  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00, // One lane
    SZ_HALF = 2'b01, // Two lanes, 2-byte aligned
    SZ_WORD = 2'b10  // All lanes, 4-byte aligned
  } acc_size_e;

  // One write enable per byte lane
  typedef logic [`MEM_NB_COL-1:0] lane_t;

endpackage

// File: lsu_op_pkg.sv
// Opcodes seen by the memory-access stage
package lsu_op_pkg;

  localparam int LSU_OP_W = 4; // Opcode field width

  // Load/store operation carried with each request
  typedef enum logic [LSU_OP_W-1:0] {
    OP_NONE = 4'h0, // Bubble, no memory access
    OP_LB   = 4'h1, // Load byte, sign-extended
    OP_LBU  = 4'h2, // Load byte, zero-extended
    OP_LH   = 4'h3, // Load halfword, sign-extended
    OP_LHU  = 4'h4, // Load halfword, zero-extended
    OP_LW   = 4'h5, // Load word
    OP_SB   = 4'h6, // Store byte
    OP_SH   = 4'h7, // Store halfword
    OP_SW   = 4'h8  // Store word
  } lsu_op_e;

endpackage

// File: mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Word address width, 1024 words of data memory
`define MEM_ADDR_W 10

`define MEM_DATA_W 32 // Data path width

`define MEM_NB_COL 4  // Byte lanes per word

`define MEM_COL_W 8   // Bits per lane

`endif
